//--- rom_init.hex
// One 32-bit instruction word per line, word addresses 0 to 63 in order
003CFF00
013CFE03
023CFD06
033CFC09
043CFB0C
053CFA0F
063CF912
073CF815
083CF718
093CF61B
0A3CF51E
0B3CF421
0C3CF324
0D3CF227
0E3CF12A
0F3CF02D
103CEF30
113CEE33
123CED36
133CEC39
143CEB3C
153CEA3F
163CE942
173CE845
183CE748
193CE64B
1A3CE54E
1B3CE451
1C3CE354
1D3CE257
1E3CE15A
1F3CE05D
203CDF60
213CDE63
223CDD66
233CDC69
243CDB6C
253CDA6F
263CD972
273CD875
283CD778
293CD67B
2A3CD57E
2B3CD481
2C3CD384
2D3CD287
2E3CD18A
2F3CD08D
303CCF90
313CCE93
323CCD96
333CCC99
343CCB9C
353CCA9F
363CC9A2
373CC8A5
383CC7A8
393CC6AB
3A3CC5AE
3B3CC4B1
3C3CC3B4
3D3CC2B7
3E3CC1BA
3F3CC0BD

//--- run.sh
#!/bin/sh
# Builds the fetch subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch -f src.f -o sim_fetch

out=$(./obj_dir/sim_fetch) || true
echo "$out"
echo "$out" | grep -q "Simulation PASSED"

//--- src.f
verilog/fetch_pkg.sv
verilog/burst_memory.sv
verilog/mem_arbiter.sv
verilog/icache.sv
verilog/fetch_top.sv
verif/fetch_checker.sv
verif/tb_fetch.sv

//--- verif/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
    input  logic             Clk,
    input  logic             rst,
    input  logic             read_en     [fetch_pkg::NUM_PORTS],
    input  fetch_pkg::addr_t read_addr   [fetch_pkg::NUM_PORTS],
    input  fetch_pkg::word_t instr       [fetch_pkg::NUM_PORTS],
    input  logic             ready       [fetch_pkg::NUM_PORTS],
    input  logic             busy        [fetch_pkg::NUM_PORTS],
    input  logic             exp_hit     [fetch_pkg::NUM_PORTS],
    output int               port_errors [fetch_pkg::NUM_PORTS],
    output int               checks
);

    localparam int READY_LIMIT = 30;  // Cycles before a fetch counts as lost

    fetch_pkg::word_t rom [fetch_pkg::MEM_WORDS];

    // Tag model per port, set and way
    logic [31:0] model_tag   [fetch_pkg::NUM_PORTS][fetch_pkg::NUM_SETS][fetch_pkg::NUM_WAYS];
    logic        model_valid [fetch_pkg::NUM_PORTS][fetch_pkg::NUM_SETS][fetch_pkg::NUM_WAYS];
    int          model_rr    [fetch_pkg::NUM_PORTS][fetch_pkg::NUM_SETS];

    logic             pending   [fetch_pkg::NUM_PORTS];
    logic             prev_en   [fetch_pkg::NUM_PORTS];
    logic             pred_hit  [fetch_pkg::NUM_PORTS];
    logic             busy_seen [fetch_pkg::NUM_PORTS];
    fetch_pkg::addr_t cur_addr  [fetch_pkg::NUM_PORTS];
    int               start_cyc [fetch_pkg::NUM_PORTS];
    int               cyc;

    initial begin
        $readmemh("rom_init.hex", rom);
        cyc    = 0;
        checks = 0;
        for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
            port_errors[p] = 0;
        end
    end

    task automatic value_error(input int p, input string sig, input string expected,
                               input string actual);
        $display("[ERROR] %0d ns port %0d %s: expected %s, actual %s",
                 $time, p, sig, expected, actual);
        port_errors[p]++;
    endtask

    task automatic clear_model();
        for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
            pending[p] = 1'b0;
            prev_en[p] = 1'b0;
            for (int s = 0; s < fetch_pkg::NUM_SETS; s++) begin
                model_rr[p][s] = 0;
                for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
                    model_valid[p][s][w] = 1'b0;
                end
            end
        end
    endtask

    // Hit test, then fill on a miss: lowest invalid way, else round-robin
    task automatic model_access(input int p, input fetch_pkg::addr_t a, output logic hit);
        int          set_i;
        int          way;
        logic [31:0] tag;
        set_i = int'((a >> fetch_pkg::OFFSET_BITS) % fetch_pkg::NUM_SETS);
        tag   = a >> (fetch_pkg::OFFSET_BITS + fetch_pkg::SET_BITS);
        hit   = 1'b0;
        way   = -1;
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            if (model_valid[p][set_i][w] && model_tag[p][set_i][w] == tag) hit = 1'b1;
        end
        if (!hit) begin
            for (int w = fetch_pkg::NUM_WAYS - 1; w >= 0; w--) begin
                if (!model_valid[p][set_i][w]) way = w;
            end
            if (way < 0) begin
                way = model_rr[p][set_i];
                model_rr[p][set_i] = (model_rr[p][set_i] + 1) % fetch_pkg::NUM_WAYS;
            end
            model_valid[p][set_i][way] = 1'b1;
            model_tag[p][set_i][way]   = tag;
        end
    endtask

    task automatic finish_fetch(input int p);
        int               lat;
        int               idx;
        fetch_pkg::word_t want;
        lat  = cyc - start_cyc[p] - 1;  // Cycles from sampled request to ready
        idx  = int'((cur_addr[p] / 4) % fetch_pkg::MEM_WORDS);
        want = rom[idx];
        checks++;
        pending[p] = 1'b0;
        if (instr[p] !== want) begin
            value_error(p, "instr", $sformatf("%h", want), $sformatf("%h", instr[p]));
        end
        if (pred_hit[p]) begin
            if (lat != 1) value_error(p, "ready latency", "1", $sformatf("%0d", lat));
            if (busy_seen[p]) value_error(p, "busy", "0", "1");
        end else begin
            if (lat <= 1) value_error(p, "ready latency", "more than 1", $sformatf("%0d", lat));
            if (!busy_seen[p]) value_error(p, "busy", "1", "0");
        end
    endtask

    task automatic watch_port(input int p);
        logic hit;
        if (pending[p]) begin
            if (busy[p]) busy_seen[p] = 1'b1;
            if (ready[p]) begin
                finish_fetch(p);
            end else if (cyc - start_cyc[p] > READY_LIMIT) begin
                $display("port %0d: no ready within %0d cycles of the fetch from %h",
                         p, READY_LIMIT, cur_addr[p]);
                port_errors[p]++;
                pending[p] = 1'b0;
            end
        end else if (ready[p]) begin
            $display("port %0d: ready pulsed at %0d ns with no fetch outstanding", p, $time);
            port_errors[p]++;
        end
        // A new fetch starts where read_en rises
        if (read_en[p] && !prev_en[p]) begin
            pending[p]   = 1'b1;
            cur_addr[p]  = read_addr[p];
            start_cyc[p] = cyc;
            busy_seen[p] = busy[p];
            model_access(p, read_addr[p], hit);
            pred_hit[p] = hit;
            if (hit !== exp_hit[p]) begin
                $display("port %0d: table expects a %s at %h but the cache model predicts a %s",
                         p, exp_hit[p] ? "hit" : "miss", read_addr[p], hit ? "hit" : "miss");
                port_errors[p]++;
            end
        end
        prev_en[p] = read_en[p];
    endtask

    // Sampled away from the rising edge
    always @(negedge Clk) begin
        cyc++;
        if (rst) begin
            clear_model();
        end else begin
            for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
                watch_port(p);
            end
        end
    end

endmodule

//--- verif/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

    localparam int NUM_TESTS   = 24;
    localparam int CLK_PERIOD  = 8;
    localparam int TEST_CYCLES = 40;  // Watchdog budget per table entry
    localparam int WAIT_LIMIT  = 40;  // Driver gives up on ready after this

    logic             Clk;
    logic             rst;
    logic             read_en     [fetch_pkg::NUM_PORTS];
    fetch_pkg::addr_t read_addr   [fetch_pkg::NUM_PORTS];
    fetch_pkg::word_t instr       [fetch_pkg::NUM_PORTS];
    logic             ready       [fetch_pkg::NUM_PORTS];
    logic             busy        [fetch_pkg::NUM_PORTS];
    logic             exp_hit     [fetch_pkg::NUM_PORTS];
    int               port_errors [fetch_pkg::NUM_PORTS];
    int               checks;

    // Stimulus table, one fetch per entry
    string            tbl_name [NUM_TESTS];
    int               tbl_port [NUM_TESTS];
    fetch_pkg::addr_t tbl_addr [NUM_TESTS];
    logic             tbl_hit  [NUM_TESTS];  // Expected outcome
    logic             tbl_pair [NUM_TESTS];  // Issued together with the next entry
    int               n_built;
    int               passed;
    int               failed;
    integer           seed;

    fetch_top uut (
        .Clk       (Clk),
        .rst       (rst),
        .read_en   (read_en),
        .read_addr (read_addr),
        .instr     (instr),
        .ready     (ready),
        .busy      (busy)
    );

    fetch_checker u_fetch_check (
        .Clk         (Clk),
        .rst         (rst),
        .read_en     (read_en),
        .read_addr   (read_addr),
        .instr       (instr),
        .ready       (ready),
        .busy        (busy),
        .exp_hit     (exp_hit),
        .port_errors (port_errors),
        .checks      (checks)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    task automatic add_test(input string name, input int port, input fetch_pkg::addr_t addr,
                            input logic hit, input logic pair);
        tbl_name[n_built] = name;
        tbl_port[n_built] = port;
        tbl_addr[n_built] = addr;
        tbl_hit[n_built]  = hit;
        tbl_pair[n_built] = pair;
        n_built++;
    endtask

    task automatic build_table();
        logic [31:0]      rnd;
        fetch_pkg::addr_t fill [1:5];
        // Five tags in set 5, random upper bits
        for (int k = 1; k <= 5; k++) begin
            rnd     = $random(seed);
            fill[k] = {rnd[31:12], 5'(k), 3'd5, 2'(k), 2'b00};
        end
        add_test("cold_miss",    0, 32'h0000_0024, 1'b0, 1'b0);
        add_test("repeat_hit",   0, 32'h0000_0024, 1'b1, 1'b0);
        add_test("block_word0",  0, 32'h0000_0020, 1'b1, 1'b0);
        add_test("block_word2",  0, 32'h0000_0028, 1'b1, 1'b0);
        add_test("block_word3",  0, 32'h0000_002C, 1'b1, 1'b0);
        add_test("dual_miss_p0", 0, 32'h0000_0044, 1'b0, 1'b1);
        add_test("dual_miss_p1", 1, 32'h0000_00B8, 1'b0, 1'b0);
        add_test("own_hit_p0",   0, 32'h0000_0048, 1'b1, 1'b0);
        add_test("private_p1",   1, 32'h0000_0044, 1'b0, 1'b0);
        add_test("own_hit_p1",   1, 32'h0000_00B0, 1'b1, 1'b0);
        add_test("fill_tag1",    1, fill[1],       1'b0, 1'b0);
        add_test("fill_tag2",    1, fill[2],       1'b0, 1'b0);
        add_test("fill_tag3",    1, fill[3],       1'b0, 1'b0);
        add_test("fill_tag4",    1, fill[4],       1'b0, 1'b0);
        add_test("evict_tag5",   1, fill[5],       1'b0, 1'b0);
        add_test("reread_tag1",  1, fill[1],       1'b0, 1'b0);
        add_test("keep_tag4",    1, fill[4],       1'b1, 1'b0);
        add_test("reread_tag2",  1, fill[2],       1'b0, 1'b0);
        add_test("keep_tag5",    1, fill[5],       1'b1, 1'b0);
        add_test("alias_tag2",   0, 32'h0000_0124, 1'b0, 1'b0);
        add_test("alias_orig",   0, 32'h0000_0024, 1'b1, 1'b0);
        add_test("alias_tag34",  0, 32'h0000_1124, 1'b0, 1'b0);
        add_test("alias_hit_p0", 0, 32'h0000_1124, 1'b1, 1'b1);
        add_test("alias_miss_p1", 1, 32'h0000_0124, 1'b0, 1'b0);
    endtask

    // Holds the request until ready, then drops it
    task automatic fetch(input int port, input fetch_pkg::addr_t addr, input logic hit);
        int waited;
        @(posedge Clk);
        read_en[port]   <= 1'b1;
        read_addr[port] <= addr;
        exp_hit[port]   <= hit;
        waited = 0;
        do begin
            @(negedge Clk);
            waited++;
        end while (!ready[port] && waited < WAIT_LIMIT);
        @(posedge Clk);
        read_en[port] <= 1'b0;
    endtask

    task automatic report_test(input int n, input int errs_before);
        int p;
        p = tbl_port[n];
        if (port_errors[p] == errs_before) passed++;
        else failed++;
        $display("test %0d %s port %0d addr %h %s: %s", n, tbl_name[n], p, tbl_addr[n],
                 tbl_hit[n] ? "hit" : "miss", (port_errors[p] == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        int i;
        int total_errors;
        int base_err [fetch_pkg::NUM_PORTS];
        rst     = 1'b1;
        seed    = 32'h86ed;
        n_built = 0;
        passed  = 0;
        failed  = 0;
        for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
            read_en[p]   = 1'b0;
            read_addr[p] = '0;
            exp_hit[p]   = 1'b0;
        end
        build_table();
        repeat (4) @(posedge Clk);
        rst <= 1'b0;

        i = 0;
        while (i < NUM_TESTS) begin
            base_err[0] = port_errors[0];
            base_err[1] = port_errors[1];
            if (tbl_pair[i] && i + 1 < NUM_TESTS) begin
                fork
                    fetch(tbl_port[i], tbl_addr[i], tbl_hit[i]);
                    fetch(tbl_port[i + 1], tbl_addr[i + 1], tbl_hit[i + 1]);
                join
                report_test(i, base_err[tbl_port[i]]);
                report_test(i + 1, base_err[tbl_port[i + 1]]);
                i = i + 2;
            end else begin
                fetch(tbl_port[i], tbl_addr[i], tbl_hit[i]);
                report_test(i, base_err[tbl_port[i]]);
                i++;
            end
        end

        total_errors = port_errors[0] + port_errors[1];
        if (checks != NUM_TESTS) begin
            $display("checker compared %0d fetches but %0d were issued", checks, NUM_TESTS);
        end
        $display("tests %0d, passed %0d, failed %0d, fetches compared %0d, errors %0d",
                 NUM_TESTS, passed, failed, checks, total_errors);
        if (failed == 0 && total_errors == 0 && checks == NUM_TESTS) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog: the run did not finish within %0d cycles",
                 NUM_TESTS * TEST_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- verilog/burst_memory.sv
`timescale 1ns/1ps

module burst_memory (
    input  logic                Clk,
    input  logic                rst,
    input  fetch_pkg::mem_req_t req,
    output fetch_pkg::mem_rsp_t rsp
);

    fetch_pkg::word_t mem [fetch_pkg::MEM_WORDS];

    fetch_pkg::mem_state_t state;
    logic [$clog2(fetch_pkg::MEM_LATENCY + 1)-1:0] wait_cnt;
    logic [$clog2(fetch_pkg::MEM_WORDS)-1:0] base_idx;  // Word address mod depth
    logic [$clog2(fetch_pkg::MEM_WORDS)-1:0] rd_idx;
    fetch_pkg::beat_cnt_t beat;

    initial $readmemh("rom_init.hex", mem);

    assign rd_idx = base_idx + ($clog2(fetch_pkg::MEM_WORDS))'(beat);

    always_ff @(posedge Clk) begin
        if (rst) begin
            state     <= fetch_pkg::MEM_IDLE;
            rsp.valid <= 1'b0;
            rsp.last  <= 1'b0;
            wait_cnt  <= '0;
            beat      <= '0;
        end else begin
            case (state)
                fetch_pkg::MEM_IDLE: begin
                    rsp.valid <= 1'b0;
                    rsp.last  <= 1'b0;
                    if (req.valid) begin
                        base_idx <= req.addr[fetch_pkg::BYTE_BITS +: $clog2(fetch_pkg::MEM_WORDS)];
                        wait_cnt <= ($clog2(fetch_pkg::MEM_LATENCY + 1))'(fetch_pkg::MEM_LATENCY - 1);
                        beat     <= '0;
                        state    <= fetch_pkg::MEM_WAIT;
                    end
                end
                fetch_pkg::MEM_WAIT: begin
                    if (wait_cnt == '0) begin
                        rsp.valid <= 1'b1;  // First beat
                        rsp.last  <= 1'b0;
                        beat      <= beat + 1'b1;
                        state     <= fetch_pkg::MEM_BURST;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                fetch_pkg::MEM_BURST: begin
                    if (rsp.valid && rsp.last) begin
                        rsp.valid <= 1'b0;  // Last beat shown, free again
                        rsp.last  <= 1'b0;
                        state     <= fetch_pkg::MEM_IDLE;
                    end else begin
                        rsp.valid <= 1'b1;
                        rsp.last  <= (beat == fetch_pkg::beat_cnt_t'(fetch_pkg::BLOCK_WORDS - 1));
                        beat      <= beat + 1'b1;
                    end
                end
                default: state <= fetch_pkg::MEM_IDLE;
            endcase
        end
    end

    // Beat data, first word leaves at the end of the wait
    always_ff @(posedge Clk) begin
        if ((state == fetch_pkg::MEM_WAIT && wait_cnt == '0) ||
            (state == fetch_pkg::MEM_BURST && !(rsp.valid && rsp.last))) begin
            rsp.data <= mem[rd_idx];
        end
    end

    assert property (@(posedge Clk) disable iff (rst)
        $rose(req.valid) |-> state == fetch_pkg::MEM_IDLE)
        else $error("burst_memory: request arrived during a burst");

endmodule

//--- verilog/fetch_pkg.sv
package fetch_pkg;

    // Cache geometry, shared by both cores
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;

    localparam int MEM_WORDS   = 64;  // Addresses wrap modulo this size
    localparam int MEM_LATENCY = 2;   // Accept to first beat
    localparam int NUM_PORTS   = 2;

    // Byte address fields
    localparam int BYTE_BITS   = 2;
    localparam int OFFSET_BITS = BYTE_BITS + $clog2(BLOCK_WORDS);
    localparam int SET_BITS    = $clog2(NUM_SETS);
    localparam int TAG_BITS    = 32 - SET_BITS - OFFSET_BITS;

    typedef logic [31:0]                    addr_t;
    typedef logic [31:0]                    word_t;
    typedef logic [TAG_BITS-1:0]            tag_t;
    typedef logic [SET_BITS-1:0]            set_idx_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]    way_idx_t;
    typedef logic [$clog2(BLOCK_WORDS)-1:0] beat_cnt_t;
    typedef logic [$clog2(NUM_PORTS)-1:0]   port_idx_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;   // Block aligned
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;   // Final beat of the burst
    } mem_rsp_t;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL} cache_state_t;
    typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_t;
    typedef enum logic [1:0] {MEM_IDLE, MEM_WAIT, MEM_BURST} mem_state_t;

endpackage

//--- verilog/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic             Clk,
    input  logic             rst,
    input  logic             read_en   [fetch_pkg::NUM_PORTS],
    input  fetch_pkg::addr_t read_addr [fetch_pkg::NUM_PORTS],
    output fetch_pkg::word_t instr     [fetch_pkg::NUM_PORTS],
    output logic             ready     [fetch_pkg::NUM_PORTS],
    output logic             busy      [fetch_pkg::NUM_PORTS]
);

    // Cache side of the arbiter
    fetch_pkg::mem_req_t cache_req [fetch_pkg::NUM_PORTS];
    fetch_pkg::mem_rsp_t cache_rsp [fetch_pkg::NUM_PORTS];

    // Shared memory port
    fetch_pkg::mem_req_t mem_req;
    fetch_pkg::mem_rsp_t mem_rsp;

    for (genvar p = 0; p < fetch_pkg::NUM_PORTS; p++) begin : g_core
        icache u_icache (
            .Clk       (Clk),
            .rst       (rst),
            .read_en   (read_en[p]),
            .read_addr (read_addr[p]),
            .instr     (instr[p]),
            .ready     (ready[p]),
            .busy      (busy[p]),
            .mem_req   (cache_req[p]),
            .mem_rsp   (cache_rsp[p])
        );
    end

    mem_arbiter u_arbiter (
        .Clk     (Clk),
        .rst     (rst),
        .req     (cache_req),
        .rsp     (cache_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    burst_memory u_memory (
        .Clk (Clk),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

//--- verilog/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                Clk,
    input  logic                rst,
    input  logic                read_en,
    input  fetch_pkg::addr_t    read_addr,
    output fetch_pkg::word_t    instr,
    output logic                ready,
    output logic                busy,
    output fetch_pkg::mem_req_t mem_req,
    input  fetch_pkg::mem_rsp_t mem_rsp
);

    fetch_pkg::cache_state_t state;
    fetch_pkg::addr_t        req_addr;   // Address under lookup or refill
    logic                    req_valid;

    // Storage arrays
    fetch_pkg::tag_t  tag_mem  [fetch_pkg::NUM_SETS][fetch_pkg::NUM_WAYS];
    fetch_pkg::word_t data_mem [fetch_pkg::NUM_SETS][fetch_pkg::NUM_WAYS][fetch_pkg::BLOCK_WORDS];
    logic [fetch_pkg::NUM_WAYS-1:0] valid_bits [fetch_pkg::NUM_SETS];
    fetch_pkg::way_idx_t rr_ptr [fetch_pkg::NUM_SETS];  // Next victim when set is full

    fetch_pkg::way_idx_t  fill_way;
    fetch_pkg::beat_cnt_t beat_cnt;
    fetch_pkg::word_t     fwd_word;  // Requested word, caught mid-burst

    fetch_pkg::set_idx_t  req_set;
    fetch_pkg::tag_t      req_tag;
    fetch_pkg::beat_cnt_t req_off;

    logic                hit;
    fetch_pkg::way_idx_t hit_way;
    logic                has_invalid;
    fetch_pkg::way_idx_t victim_way;
    logic                accept;
    logic                beat_in;

    assign req_set = req_addr[fetch_pkg::OFFSET_BITS +: fetch_pkg::SET_BITS];
    assign req_tag = req_addr[fetch_pkg::OFFSET_BITS + fetch_pkg::SET_BITS +: fetch_pkg::TAG_BITS];
    assign req_off = req_addr[fetch_pkg::BYTE_BITS +: $bits(fetch_pkg::beat_cnt_t)];

    // Hold off one cycle after ready so a held request is not taken twice
    assign accept  = (state == fetch_pkg::IDLE) && read_en && !ready;
    assign beat_in = (state == fetch_pkg::REFILL) && mem_rsp.valid;

    assign mem_req = '{
        valid: req_valid,
        addr:  {req_addr[31:fetch_pkg::OFFSET_BITS], {fetch_pkg::OFFSET_BITS{1'b0}}}
    };

    // Tag compare across the indexed set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < fetch_pkg::NUM_WAYS; w++) begin
            if (valid_bits[req_set][w] && tag_mem[req_set][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = fetch_pkg::way_idx_t'(w);
            end
        end
    end

    // Lowest invalid way first, else the set's pointer
    always_comb begin
        has_invalid = 1'b0;
        victim_way  = rr_ptr[req_set];
        for (int w = fetch_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_bits[req_set][w]) begin
                has_invalid = 1'b1;
                victim_way  = fetch_pkg::way_idx_t'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state     <= fetch_pkg::IDLE;
            ready     <= 1'b0;
            busy      <= 1'b0;
            req_valid <= 1'b0;
            beat_cnt  <= '0;
            for (int s = 0; s < fetch_pkg::NUM_SETS; s++) begin
                valid_bits[s] <= '0;
                rr_ptr[s]     <= '0;
            end
        end else begin
            ready <= 1'b0;
            case (state)
                fetch_pkg::IDLE: begin
                    if (accept) state <= fetch_pkg::LOOKUP;
                end
                fetch_pkg::LOOKUP: begin
                    if (hit) begin
                        ready <= 1'b1;
                        state <= fetch_pkg::IDLE;
                    end else begin
                        busy      <= 1'b1;
                        req_valid <= 1'b1;
                        beat_cnt  <= '0;
                        fill_way  <= victim_way;
                        if (!has_invalid) begin
                            rr_ptr[req_set] <= rr_ptr[req_set] + 1'b1;
                        end
                        state <= fetch_pkg::REFILL;
                    end
                end
                fetch_pkg::REFILL: begin
                    if (mem_rsp.valid) begin
                        req_valid <= 1'b0;  // Drop once the burst has started
                        beat_cnt  <= beat_cnt + 1'b1;
                        if (mem_rsp.last) begin
                            valid_bits[req_set][fill_way] <= 1'b1;
                            busy  <= 1'b0;
                            ready <= 1'b1;
                            state <= fetch_pkg::IDLE;
                        end
                    end
                end
                default: state <= fetch_pkg::IDLE;
            endcase
        end
    end

    // Address capture, array writes and returned word
    always_ff @(posedge Clk) begin
        if (accept) req_addr <= read_addr;
        if (state == fetch_pkg::LOOKUP && hit) begin
            instr <= data_mem[req_set][hit_way][req_off];
        end
        if (beat_in) begin
            data_mem[req_set][fill_way][beat_cnt] <= mem_rsp.data;
            if (beat_cnt == req_off) fwd_word <= mem_rsp.data;
            if (mem_rsp.last) begin
                tag_mem[req_set][fill_way] <= req_tag;
                instr <= (beat_cnt == req_off) ? mem_rsp.data : fwd_word;
            end
        end
    end

    assert property (@(posedge Clk) disable iff (rst) !(ready && busy))
        else $error("icache: ready and busy high together");

    assert property (@(posedge Clk) disable iff (rst)
        mem_req.valid |-> state == fetch_pkg::REFILL)
        else $error("icache: memory request outside refill");

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                Clk,
    input  logic                rst,
    input  fetch_pkg::mem_req_t req [fetch_pkg::NUM_PORTS],
    output fetch_pkg::mem_rsp_t rsp [fetch_pkg::NUM_PORTS],
    output fetch_pkg::mem_req_t mem_req,
    input  fetch_pkg::mem_rsp_t mem_rsp
);

    fetch_pkg::arb_state_t state;
    fetch_pkg::port_idx_t  grant;
    fetch_pkg::port_idx_t  last_served;
    fetch_pkg::port_idx_t  winner;
    logic                  any_req;

    // Scan starting after the last served port
    always_comb begin
        fetch_pkg::port_idx_t cand;
        any_req = 1'b0;
        winner  = last_served;
        for (int i = fetch_pkg::NUM_PORTS; i >= 1; i--) begin
            cand = fetch_pkg::port_idx_t'(last_served + i);
            if (req[cand].valid) begin
                any_req = 1'b1;
                winner  = cand;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state       <= fetch_pkg::ARB_IDLE;
            grant       <= '0;
            last_served <= '0;
        end else begin
            case (state)
                fetch_pkg::ARB_IDLE: begin
                    if (any_req) begin
                        grant       <= winner;
                        last_served <= winner;
                        state       <= fetch_pkg::ARB_BUSY;
                    end
                end
                fetch_pkg::ARB_BUSY: begin
                    if (mem_rsp.valid && mem_rsp.last) state <= fetch_pkg::ARB_IDLE;
                end
                default: state <= fetch_pkg::ARB_IDLE;
            endcase
        end
    end

    assign mem_req = (state == fetch_pkg::ARB_BUSY) ? req[grant] : '0;

    // Beats go to the owner only
    always_comb begin
        for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
            rsp[p] = '0;
            if (state == fetch_pkg::ARB_BUSY && grant == fetch_pkg::port_idx_t'(p)) begin
                rsp[p] = mem_rsp;
            end
        end
    end

    // Owner and its block address stay put for the whole burst
    assert property (@(posedge Clk) disable iff (rst)
        (state == fetch_pkg::ARB_BUSY) ##1 (state == fetch_pkg::ARB_BUSY)
        |-> $stable(grant) && $stable(mem_req.addr))
        else $error("mem_arbiter: grant moved during a burst");

endmodule
